// ==== Makefile ====
TOP := uartTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q '^>>> PASS' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== sim.f ====
src/uartPkg.sv
src/uartFifo.sv
src/uartRegs.sv
src/uartTx.sv
src/uartRx.sv
src/uartTop.sv
verif/uartClkGen.sv
verif/uartTb_sva.sv
verif/uartTb.sv

// ==== src/uartFifo.sv ====
`timescale 1ns/1ps

module uartFifo import uartPkg::*; (
  input  logic     clkH,
  input  logic     rst,
  input  uartByteT pushData,
  input  logic     push,
  input  logic     pop,
  output uartByteT popData,
  output logic     hasData,
  output logic     hasSpace
);

  uartByteT mem [fifoDepth];
  fifoPtrT wrPtr;
  fifoPtrT rdPtr;
  logic [fifoAddrLen:0] count;
  logic doPush;
  logic doPop;

  // Flags from the occupancy count
  assign hasData = (count != '0);
  assign hasSpace = (count != (fifoAddrLen + 1)'(fifoDepth));

  // Push while full or pop while empty is dropped
  assign doPush = push & hasSpace;
  assign doPop = pop & hasData;

  // Head entry always visible
  assign popData = mem[rdPtr];

  always_ff @(posedge clkH) begin
    if (doPush) begin
      mem[wrPtr] <= pushData;
    end
  end

  // Pointers wrap at the depth
  always_ff @(posedge clkH) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({doPush, doPop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== src/uartPkg.sv ====
package uartPkg;

  // FIFO geometry
  localparam int fifoAddrLen = 3;
  localparam int fifoDepth = 1 << fifoAddrLen;

  // Data widths
  typedef logic [7:0] uartByteT;
  typedef logic [15:0] baudDivT;
  typedef logic [1:0] regAddrT;
  typedef logic [fifoAddrLen-1:0] fifoPtrT;

  // Receiver phases
  typedef enum logic [1:0] {
    rxIdle,
    rxStart,
    rxData,
    rxStop
  } rxStateT;

  // Register map, address 3 reads as zero
  localparam regAddrT regCtrl = 2'd0;
  localparam regAddrT regBaud = 2'd1;
  localparam regAddrT regData = 2'd2;

  // Control byte bit positions
  localparam int ctrlTxEn = 7;
  localparam int ctrlRxEn = 6;
  localparam int ctrlTwoStop = 3;
  localparam int ctrlIrqWr = 1;
  localparam int ctrlIrqRd = 0;

  // Status bits in the control read-back
  localparam int statSendBusy = 3;
  localparam int statCanWrite = 1;
  localparam int statCanRead = 0;

  // Bit period after reset
  localparam baudDivT baudReset = 16'd16;

endpackage

// ==== src/uartRegs.sv ====
`timescale 1ns/1ps

module uartRegs import uartPkg::*; (
  input  logic     clkH,
  input  logic     rst,
  input  regAddrT  addr,
  input  logic     wrEn,
  input  baudDivT  wrData,
  input  logic     rdEn,
  input  uartByteT recvData,
  input  logic     recvHasData,
  input  logic     sendHasSpace,
  input  logic     sendBusy,
  output baudDivT  rdData,
  output logic     sendPush,
  output uartByteT sendData,
  output logic     recvPop,
  output baudDivT  baudDiv,
  output logic     txEn,
  output logic     rxEn,
  output logic     twoStop,
  output logic     irq
);

  uartByteT ctrlReg;
  baudDivT  baudReg;
  uartByteT status;

  // Control and divisor registers
  always_ff @(posedge clkH) begin
    if (rst) begin
      ctrlReg <= '0;
      baudReg <= baudReset;
    end else if (wrEn) begin
      case (addr)
        regCtrl: ctrlReg <= wrData[7:0];
        regBaud: baudReg <= wrData;
        default: ;
      endcase
    end
  end

  // Data register writes go straight into the send FIFO
  assign sendPush = wrEn & (addr == regData);
  assign sendData = wrData[7:0];

  // Reading data pops the receive FIFO head at the next clock
  assign recvPop = rdEn & (addr == regData);

  assign baudDiv = baudReg;
  assign txEn = ctrlReg[ctrlTxEn];
  assign rxEn = ctrlReg[ctrlRxEn];
  assign twoStop = ctrlReg[ctrlTwoStop];

  // Status byte, enables in the top bits
  always_comb begin
    status = '0;
    status[ctrlTxEn] = txEn;
    status[ctrlRxEn] = rxEn;
    status[statSendBusy] = sendBusy;
    status[statCanWrite] = sendHasSpace;
    status[statCanRead] = recvHasData;
  end

  // Read-back mux
  always_comb begin
    rdData = '0;
    if (rdEn) begin
      case (addr)
        regCtrl: rdData = {8'h00, status};
        regBaud: rdData = baudReg;
        regData: rdData = {8'h00, recvData};
        default: rdData = '0;
      endcase
    end
  end

  // Flag interrupts, each masked by its enable
  assign irq = (recvHasData & ctrlReg[ctrlIrqRd]) | (sendHasSpace & ctrlReg[ctrlIrqWr]);

endmodule

// ==== src/uartRx.sv ====
`timescale 1ns/1ps

module uartRx import uartPkg::*; (
  input  logic     clkH,
  input  logic     rst,
  input  logic     rxEn,
  input  baudDivT  baudDiv,
  input  logic     rxPin,
  output uartByteT recvData,
  output logic     recvPush
);

  logic [1:0] rxSync;
  logic rxPrev;
  logic lineNow;
  logic fallEdge;
  logic tick;
  rxStateT state;
  baudDivT bitCnt;
  logic [3:0] bitIdx;
  uartByteT shiftReg;

  // Two-flop synchronizer plus history for edge detect
  always_ff @(posedge clkH) begin
    if (rst) begin
      rxSync <= 2'b11;
      rxPrev <= 1'b1;
    end else begin
      rxSync <= {rxSync[0], rxPin};
      rxPrev <= rxSync[1];
    end
  end

  assign lineNow = rxSync[1];
  assign fallEdge = rxPrev & ~lineNow;
  assign tick = (bitCnt == '0);

  // Frame sequencer
  always_ff @(posedge clkH) begin
    if (rst) begin
      state <= rxIdle;
      bitCnt <= '0;
      bitIdx <= '0;
    end else if (!rxEn) begin
      state <= rxIdle;
      bitCnt <= '0;
    end else begin
      case (state)
        rxIdle: begin
          if (fallEdge) begin
            // Half a bit to reach mid start bit
            bitCnt <= baudDiv >> 1;
            state <= rxStart;
          end
        end
        rxStart: begin
          if (!tick) begin
            bitCnt <= bitCnt - 1'b1;
          end else if (!lineNow) begin
            bitCnt <= baudDiv - 1'b1;
            bitIdx <= 4'd8;
            state <= rxData;
          end else begin
            // Glitch, not a real start bit
            state <= rxIdle;
          end
        end
        rxData: begin
          if (!tick) begin
            bitCnt <= bitCnt - 1'b1;
          end else begin
            bitCnt <= baudDiv - 1'b1;
            bitIdx <= bitIdx - 1'b1;
            if (bitIdx == 4'd1) begin
              state <= rxStop;
            end
          end
        end
        rxStop: begin
          if (!tick) begin
            bitCnt <= bitCnt - 1'b1;
          end else begin
            state <= rxIdle;
          end
        end
        default: state <= rxIdle;
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clkH) begin
    if (rxEn && (state == rxData) && tick) begin
      shiftReg <= {lineNow, shiftReg[7:1]};
    end
  end

  assign recvData = shiftReg;
  assign recvPush = rxEn & (state == rxStop) & tick;

endmodule

// ==== src/uartTop.sv ====
`timescale 1ns/1ps

module uartTop import uartPkg::*; (
  input  logic    clkH,
  input  logic    rst,
  input  regAddrT addr,
  input  logic    wrEn,
  input  baudDivT wrData,
  input  logic    rdEn,
  input  logic    rxPin,
  output baudDivT rdData,
  output logic    txPin,
  output logic    irq
);

  // Send path
  logic sendPush;
  uartByteT sendData;
  uartByteT sendHead;
  logic sendHasData;
  logic sendHasSpace;
  logic sendPop;
  logic sendBusy;

  // Receive path
  logic recvPush;
  uartByteT recvByte;
  uartByteT recvHead;
  logic recvHasData;
  logic recvPop;

  // Codec configuration
  baudDivT baudDiv;
  logic txEn;
  logic rxEn;
  logic twoStop;

  uartRegs regs (
    .clkH(clkH),
    .rst(rst),
    .addr(addr),
    .wrEn(wrEn),
    .wrData(wrData),
    .rdEn(rdEn),
    .recvData(recvHead),
    .recvHasData(recvHasData),
    .sendHasSpace(sendHasSpace),
    .sendBusy(sendBusy),
    .rdData(rdData),
    .sendPush(sendPush),
    .sendData(sendData),
    .recvPop(recvPop),
    .baudDiv(baudDiv),
    .txEn(txEn),
    .rxEn(rxEn),
    .twoStop(twoStop),
    .irq(irq)
  );

  uartFifo sendFifo (
    .clkH(clkH),
    .rst(rst),
    .pushData(sendData),
    .push(sendPush),
    .pop(sendPop),
    .popData(sendHead),
    .hasData(sendHasData),
    .hasSpace(sendHasSpace)
  );

  // Full receive FIFO silently drops bytes
  uartFifo recvFifo (
    .clkH(clkH),
    .rst(rst),
    .pushData(recvByte),
    .push(recvPush),
    .pop(recvPop),
    .popData(recvHead),
    .hasData(recvHasData),
    .hasSpace()
  );

  uartTx tx (
    .clkH(clkH),
    .rst(rst),
    .txEn(txEn),
    .twoStop(twoStop),
    .baudDiv(baudDiv),
    .sendData(sendHead),
    .sendReady(sendHasData),
    .sendPop(sendPop),
    .sendBusy(sendBusy),
    .txPin(txPin)
  );

  uartRx rx (
    .clkH(clkH),
    .rst(rst),
    .rxEn(rxEn),
    .baudDiv(baudDiv),
    .rxPin(rxPin),
    .recvData(recvByte),
    .recvPush(recvPush)
  );

endmodule

// ==== src/uartTx.sv ====
`timescale 1ns/1ps

module uartTx import uartPkg::*; (
  input  logic     clkH,
  input  logic     rst,
  input  logic     txEn,
  input  logic     twoStop,
  input  baudDivT  baudDiv,
  input  uartByteT sendData,
  input  logic     sendReady,
  output logic     sendPop,
  output logic     sendBusy,
  output logic     txPin
);

  // Frame held inverted, so all zeros means line high
  logic [8:0] shiftReg;
  baudDivT bitCnt;
  logic [3:0] bitIdx;
  logic bitEnd;

  assign sendBusy = (bitIdx != 4'd0);

  // Start a frame only from idle
  assign sendPop = txEn & ~sendBusy & sendReady;

  // Last cycle of the current bit period
  assign bitEnd = sendBusy & (bitCnt == '0);

  always_ff @(posedge clkH) begin
    if (rst) begin
      shiftReg <= '0;
      bitCnt <= '0;
      bitIdx <= '0;
    end else if (sendPop) begin
      // Start bit in bit 0, data follows LSB first
      shiftReg <= {~sendData, 1'b1};
      bitCnt <= baudDiv - 1'b1;
      bitIdx <= twoStop ? 4'd11 : 4'd10;
    end else if (bitEnd) begin
      // Zeros shifted in become the stop bits
      shiftReg <= {1'b0, shiftReg[8:1]};
      bitCnt <= baudDiv - 1'b1;
      bitIdx <= bitIdx - 1'b1;
    end else if (sendBusy) begin
      bitCnt <= bitCnt - 1'b1;
    end
  end

  // Line forced idle when disabled
  assign txPin = ~(shiftReg[0] & txEn);

endmodule

// ==== verif/uartClkGen.sv ====
`timescale 1ns/1ps

module uartClkGen (
  output logic clkH,
  output logic rst
);

  // 100 ns period
  initial begin
    clkH = 1'b0;
    forever #50 clkH = ~clkH;
  end

  // Reset held for five cycles
  initial begin
    rst = 1'b1;
    repeat (5) @(posedge clkH);
    #1;
    rst = 1'b0;
  end

endmodule

// ==== verif/uartGolden.txt ====
# name divisor ctrl value expected, every column after the name in hex
# name prefix picks the step: reset tx tx2 rx drain irq full
reset_0 0010 00 00 02
tx_a5 0008 80 a5 a5
tx_00 0008 80 00 00
tx_ff 000c 80 ff ff
tx_3c 0006 80 3c 3c
tx_81 0010 80 81 81
tx2_5a 0008 88 5a 5a
tx2_c6 000a 88 c6 c6
rx_11 0008 40 11 11
rx_e7 0008 40 e7 e7
rx_42 0008 40 42 42
drain_0 0008 40 00 00
rx_96 000c 40 96 96
rx_0f 000c 40 0f 0f
rx_f0 000c 40 f0 f0
rx_5a 000c 40 5a 5a
drain_1 000c 40 00 00
irq_c3 0008 41 c3 c3
irq_7e 000a 41 7e 7e
full_20 0008 80 20 00
tx_d2 0008 80 d2 d2
tx2_33 0006 88 33 33
rx_a0 0010 40 a0 a0
drain_2 0010 40 00 00

// ==== verif/uartTb.sv ====
`timescale 1ns/1ps

module uartTb import uartPkg::*; ();

  logic clkH;
  logic rst;
  regAddrT addr;
  logic wrEn;
  baudDivT wrData;
  logic rdEn;
  baudDivT rdData;
  logic rxPin;
  logic txPin;
  logic irq;

  // Golden steps, one entry per line
  string names[$];
  int divs[$];
  int ctrls[$];
  int vals[$];
  int exps[$];

  // Bytes sent to the receiver, not yet read back
  int rxQueue[$];

  string curName;
  int testErrs;

  uartClkGen clkGen (.clkH(clkH), .rst(rst));

  uartTop DUT (
    .clkH(clkH),
    .rst(rst),
    .addr(addr),
    .wrEn(wrEn),
    .wrData(wrData),
    .rdEn(rdEn),
    .rxPin(rxPin),
    .rdData(rdData),
    .txPin(txPin),
    .irq(irq)
  );

  task automatic checkEqual(input string what, input int expVal, input int actVal);
    assert (expVal == actVal) else begin
      $display("Error %s %s expected %0h actual %0h", curName, what, expVal, actVal);
      testErrs++;
    end
  endtask

  task automatic writeReg(input regAddrT a, input int d);
    @(posedge clkH);
    #1;
    addr = a;
    wrData = baudDivT'(d);
    wrEn = 1'b1;
    @(posedge clkH);
    #1;
    wrEn = 1'b0;
  endtask

  // Data is valid in the cycle of rdEn
  task automatic readReg(input regAddrT a, output baudDivT d);
    @(posedge clkH);
    #1;
    addr = a;
    rdEn = 1'b1;
    @(negedge clkH);
    d = rdData;
    @(posedge clkH);
    #1;
    rdEn = 1'b0;
  endtask

  // Start, eight data bits LSB first, one stop bit
  task automatic driveLine(input int div, input uartByteT b);
    logic [9:0] frame;
    int i;
    int gap;
    frame = {1'b1, b, 1'b0};
    gap = $urandom_range(5);
    repeat (gap) @(posedge clkH);
    for (i = 0; i < 10; i++) begin
      @(posedge clkH);
      #1;
      rxPin = frame[i];
      repeat (div - 1) @(posedge clkH);
    end
  endtask

  // Samples mid-bit; high counts idle cycles from the first stop cycle
  task automatic decodeFrame(input int div, input int cap, output uartByteT b, output int high);
    int i;
    b = '0;
    while (txPin) @(negedge clkH);
    repeat (div / 2) @(negedge clkH);
    checkEqual("start bit", 0, txPin);
    for (i = 0; i < 8; i++) begin
      repeat (div) @(negedge clkH);
      b[i] = txPin;
    end
    repeat (div - div / 2) @(negedge clkH);
    high = 0;
    while (txPin && high < cap) begin
      high++;
      @(negedge clkH);
    end
  endtask

  task automatic runReset(input int div, input int expVal);
    baudDivT st;
    baudDivT bd;
    readReg(regCtrl, st);
    checkEqual("status", expVal, st);
    readReg(regBaud, bd);
    checkEqual("baud", div, bd);
    @(negedge clkH);
    checkEqual("txPin", 1, txPin);
    checkEqual("irq", 0, irq);
  endtask

  task automatic runTx(input int div, input int ctrl, input int val, input int expVal);
    uartByteT b;
    int high;
    writeReg(regBaud, div);
    writeReg(regCtrl, ctrl);
    writeReg(regData, val);
    decodeFrame(div, 3 * div, b, high);
    checkEqual("data", expVal, b);
    checkEqual("stop bit", 1, high >= div);
  endtask

  // Two queued bytes, gap measured with the divisor read back
  task automatic runTwoStop(input int div, input int ctrl, input int val, input int expVal);
    baudDivT bd;
    uartByteT b;
    int high;
    writeReg(regBaud, div);
    writeReg(regCtrl, ctrl);
    readReg(regBaud, bd);
    checkEqual("baud", div, bd);
    fork
      begin
        writeReg(regData, val);
        writeReg(regData, val);
      end
      decodeFrame(bd, 3 * bd, b, high);
    join
    checkEqual("first data", expVal, b);
    checkEqual("two stop bits", 1, high >= 2 * bd);
    decodeFrame(bd, 3 * bd, b, high);
    checkEqual("second data", expVal, b);
  endtask

  task automatic runRx(input int div, input int ctrl, input int val, input int expVal);
    writeReg(regBaud, div);
    writeReg(regCtrl, ctrl);
    driveLine(div, val);
    rxQueue.push_back(expVal);
  endtask

  task automatic runDrain(input int ctrl, input int expVal);
    baudDivT st;
    baudDivT d;
    writeReg(regCtrl, ctrl);
    while (rxQueue.size() > 0) begin
      readReg(regCtrl, st);
      checkEqual("canRead", 1, st[statCanRead]);
      readReg(regData, d);
      checkEqual("data", rxQueue.pop_front(), d);
    end
    readReg(regCtrl, st);
    checkEqual("canRead at end", expVal, st[statCanRead]);
  endtask

  task automatic runIrq(input int div, input int ctrl, input int val, input int expVal);
    baudDivT d;
    int waited;
    writeReg(regBaud, div);
    writeReg(regCtrl, ctrl);
    @(negedge clkH);
    checkEqual("irq idle", 0, irq);
    driveLine(div, val);
    waited = 0;
    while (!irq && waited < 4 * div) begin
      @(negedge clkH);
      waited++;
    end
    checkEqual("irq rise", 1, irq);
    readReg(regData, d);
    checkEqual("data", expVal, d);
    @(negedge clkH);
    checkEqual("irq fall", 0, irq);
  endtask

  // Nine writes into eight entries, only eight frames expected
  task automatic runFull(input int div, input int ctrl, input int val, input int expVal);
    baudDivT st;
    uartByteT b;
    int high;
    int i;
    writeReg(regBaud, div);
    writeReg(regCtrl, 0);
    for (i = 0; i < 9; i++) begin
      writeReg(regData, val + i);
    end
    readReg(regCtrl, st);
    checkEqual("status", expVal, st);
    writeReg(regCtrl, ctrl);
    for (i = 0; i < 8; i++) begin
      decodeFrame(div, 3 * div, b, high);
      checkEqual("data", (val + i) & 255, b);
    end
    checkEqual("idle after eighth frame", 3 * div, high);
  endtask

  function automatic string kindOf(input string n);
    int i;
    for (i = 0; i < n.len(); i++) begin
      if (n.getc(i) == "_") begin
        return n.substr(0, i - 1);
      end
    end
    return n;
  endfunction

  // Frame times a step may take, bus traffic included
  function automatic int framesOf(input string kind);
    if (kind == "tx") return 3;
    if (kind == "tx2") return 5;
    if (kind == "irq") return 2;
    if (kind == "full") return 12;
    return 1;
  endfunction

  task automatic watchdog(input int cycles);
    repeat (cycles) @(posedge clkH);
    $display("Timeout after %0d cycles, the run did not finish", cycles);
    $display(">>> FAIL");
    $finish;
  endtask

  task automatic readGolden(input int fd);
    string line;
    string nm;
    int d;
    int c;
    int v;
    int e;
    int code;
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 2 && line.getc(0) != "#") begin
        code = $sscanf(line, "%s %h %h %h %h", nm, d, c, v, e);
        if (code == 5) begin
          names.push_back(nm);
          divs.push_back(d);
          ctrls.push_back(c);
          vals.push_back(v);
          exps.push_back(e);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic runAll();
    int i;
    int passed;
    int failed;
    int limit;
    string kind;
    passed = 0;
    failed = 0;
    limit = 1000;
    for (i = 0; i < names.size(); i++) begin
      limit += 2 * framesOf(kindOf(names[i])) * 11 * divs[i];
    end
    fork
      watchdog(limit);
    join_none
    wait (rst == 1'b0);
    for (i = 0; i < names.size(); i++) begin
      curName = names[i];
      testErrs = 0;
      kind = kindOf(curName);
      if (kind == "reset") runReset(divs[i], exps[i]);
      else if (kind == "tx") runTx(divs[i], ctrls[i], vals[i], exps[i]);
      else if (kind == "tx2") runTwoStop(divs[i], ctrls[i], vals[i], exps[i]);
      else if (kind == "rx") runRx(divs[i], ctrls[i], vals[i], exps[i]);
      else if (kind == "drain") runDrain(ctrls[i], exps[i]);
      else if (kind == "irq") runIrq(divs[i], ctrls[i], vals[i], exps[i]);
      else if (kind == "full") runFull(divs[i], ctrls[i], vals[i], exps[i]);
      else begin
        $display("Step %s has an unknown kind", curName);
        testErrs++;
      end
      if (testErrs == 0) begin
        passed++;
        $display("%s ok", curName);
      end else begin
        failed++;
        $display("%s failed, %0d checks wrong", curName, testErrs);
      end
    end
    $display("Tests run %0d, passed %0d, failed %0d", names.size(), passed, failed);
    if (failed == 0 && names.size() > 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  initial begin
    int fd;
    addr = regCtrl;
    wrEn = 1'b0;
    wrData = '0;
    rdEn = 1'b0;
    rxPin = 1'b1;
    void'($urandom(81));
    fd = $fopen("verif/uartGolden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the golden file verif/uartGolden.txt");
      $display(">>> FAIL");
      $finish;
    end else begin
      readGolden(fd);
      runAll();
    end
  end

endmodule

// ==== verif/uartTb_sva.sv ====
`timescale 1ns/1ps

module uartTb_sva import uartPkg::*; (
  input logic    clkH,
  input logic    rst,
  input regAddrT addr,
  input logic    wrEn,
  input baudDivT wrData,
  input logic    txPin,
  input logic    irq,
  input logic    recvHasData,
  input logic    sendHasSpace,
  input logic    sendPop,
  input logic    sendBusy
);

  uartByteT ctrlSeen;
  baudDivT baudSeen;
  int frameLeft;

  // Control and divisor as written on the bus
  always_ff @(posedge clkH) begin
    if (rst) begin
      ctrlSeen <= '0;
      baudSeen <= baudReset;
    end else if (wrEn) begin
      if (addr == regCtrl) begin
        ctrlSeen <= wrData[7:0];
      end else if (addr == regBaud) begin
        baudSeen <= wrData;
      end
    end
  end

  // Cycles left in the frame on the line
  always_ff @(posedge clkH) begin
    if (rst) begin
      frameLeft <= 0;
    end else if (sendPop) begin
      frameLeft <= int'(baudSeen) * (ctrlSeen[ctrlTwoStop] ? 11 : 10);
    end else if (frameLeft != 0) begin
      frameLeft <= frameLeft - 1;
    end
  end

  // Disabled or idle transmitter keeps the line high
  txIdleWhenOff: assert property (@(posedge clkH) disable iff (rst)
    (!ctrlSeen[ctrlTxEn] || frameLeft == 0) |-> txPin)
    else $error("txPin low while the transmitter is disabled or idle");

  // Each FIFO flag masked by its own enable
  irqFollowsFlags: assert property (@(posedge clkH) disable iff (rst)
    irq == ((recvHasData & ctrlSeen[ctrlIrqRd]) | (sendHasSpace & ctrlSeen[ctrlIrqWr])))
    else $error("irq does not follow the enabled FIFO flags");

  // Busy covers the whole frame
  busyMatchesFrame: assert property (@(posedge clkH) disable iff (rst)
    sendBusy == (frameLeft != 0))
    else $error("sendBusy does not span the frame");

  // One frame at a time
  noStartWhileBusy: assert property (@(posedge clkH) disable iff (rst)
    sendPop |-> (frameLeft == 0))
    else $error("frame started while the transmitter was busy");

  // Start bit appears together with busy
  startBitLow: assert property (@(posedge clkH) disable iff (rst) $rose(sendBusy) |-> !txPin)
    else $error("line not low at the start of a frame");

endmodule

bind uartTop uartTb_sva sva (
  .clkH(clkH),
  .rst(rst),
  .addr(addr),
  .wrEn(wrEn),
  .wrData(wrData),
  .txPin(txPin),
  .irq(irq),
  .recvHasData(recvHasData),
  .sendHasSpace(sendHasSpace),
  .sendPop(sendPop),
  .sendBusy(sendBusy)
);
